// File: run_sim.sh
#!/usr/bin/env bash
# build the AXI SRAM slave testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

log_file="sim.log"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sources.f --top-module tb_axi_sram -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_axi_sram > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx '>>> PASS' "$log_file"; then
	echo "test passed"
	exit 0
else
	echo "pass line not found in $log_file"
	exit 1
fi

// File: source/axi_r_channel.sv
`timescale 1ns/100ps
`default_nettype none

module axi_r_channel
	import axi_sram_pkg::*;
(
	input  wire logic              ACLK,
	input  wire logic              ARESETn,
	// read address
	input  wire logic              ar_valid,
	input  wire axi_req_t          ar,
	output logic                   ar_ready,
	// read data
	input  wire logic              r_ready,
	output logic                   r_valid,
	output logic [DATA_W-1:0]      r_data,
	output resp_e                  r_resp,
	output logic                   r_last,
	// sram read port, data one cycle after rd_en
	output logic                   rd_en,
	output logic [IDX_W-1:0]       rd_index,
	input  wire logic [DATA_W-1:0] rd_data
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_ISSUE,
		R_DRAIN
	} r_state_e;

	r_state_e   state;
	logic       ar_hs;
	logic       r_free;
	logic       issue;
	logic       load;
	// reads still to issue, minus one
	logic [7:0] cnt_q;
	logic       err_q;
	logic [2:0] size_q;
	burst_e     burst_q;
	axi_addr_u  addr_q;
	// beat sitting on rd_data
	logic       s1_valid;
	logic       s1_last;

	assign ar_ready = (state == R_ADDR);
	assign ar_hs    = ar_valid && ar_ready;

	// --------------------
	// output register empty or leaving this cycle
	assign r_free = !r_valid || r_ready;
	// issue and load share the gate, so rd_data never gets overwritten unread
	assign issue  = (state == R_ISSUE) && r_free;
	assign load   = s1_valid && r_free;

	// error bursts run the pipeline without reading
	assign rd_en    = issue && !err_q;
	assign rd_index = addr_q.word.index;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state    <= R_IDLE;
			cnt_q    <= '0;
			err_q    <= 1'b0;
			s1_valid <= 1'b0;
			r_valid  <= 1'b0;
		end else begin
			case (state)
				R_IDLE: begin
					if (ar_valid) begin
						state <= R_ADDR;
					end
				end
				R_ADDR: begin
					if (ar_valid) begin
						state <= R_ISSUE;
						cnt_q <= ar.len;
						err_q <= req_error(ar);
					end
				end
				R_ISSUE: begin
					if (issue) begin
						cnt_q <= cnt_q - 8'd1;
						if (cnt_q == 8'd0) begin
							state <= R_DRAIN;
						end
					end
				end
				default: begin
					// wait for the last beat to leave
					if (r_valid && r_ready && r_last) begin
						state <= R_IDLE;
					end
				end
			endcase
			// stage on rd_data
			if (issue) begin
				s1_valid <= 1'b1;
			end else if (load) begin
				s1_valid <= 1'b0;
			end
			// R output register
			if (load) begin
				r_valid <= 1'b1;
			end else if (r_ready) begin
				r_valid <= 1'b0;
			end
		end
	end

	// --------------------
	// burst parameters, beat address and R payload
	always_ff @(posedge ACLK) begin
		if (ar_hs) begin
			size_q           <= ar.size;
			burst_q          <= ar.burst;
			addr_q.byte_addr <= ar.addr[MEM_ADDR_W-1:0];
		end else if (issue) begin
			addr_q <= next_beat_addr(addr_q, size_q, burst_q);
		end
		if (issue) begin
			s1_last <= (cnt_q == 8'd0);
		end
		if (load) begin
			r_data <= err_q ? '0 : rd_data;
			r_resp <= err_q ? RESP_SLVERR : RESP_OKAY;
			r_last <= s1_last;
		end
	end

endmodule

`default_nettype wire

// File: source/axi_sram_pkg.sv
`default_nettype none

package axi_sram_pkg;

	// --------------------
	// bus and memory geometry
	localparam int DATA_W     = 32;
	localparam int STRB_W     = 4;
	// bits per byte lane
	localparam int LANE_W     = DATA_W / STRB_W;
	localparam int ADDR_W     = 32;
	// byte address bits seen by the sram, 4 KiB then wrap
	localparam int MEM_ADDR_W = 12;
	localparam int MEM_WORDS  = 1024;
	// byte offset inside one word, rest is the word index
	localparam int OFFS_W     = $clog2(STRB_W);
	localparam int IDX_W      = MEM_ADDR_W - OFFS_W;

	// --------------------
	// AXI encodings
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// one byte address, read flat for stepping or split for sram index and lanes
	typedef union packed {
		logic [MEM_ADDR_W-1:0] byte_addr;
		struct packed {
			logic [IDX_W-1:0]  index;
			logic [OFFS_W-1:0] offset;
		} word;
	} axi_addr_u;

	// --------------------
	// channel payloads
	// AW and AR request, len is beats minus one
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		burst_e            burst;
	} axi_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} w_beat_t;

	typedef struct packed {
		logic              en;
		logic [IDX_W-1:0]  index;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] mask;
	} sram_wr_t;

	// --------------------
	// burst helpers shared by both engines
	// only FIXED and INCR up to one word per beat are served
	function automatic logic req_error(input axi_req_t req);
		return ((req.burst != BURST_FIXED) && (req.burst != BURST_INCR)) ||
			(req.size > 3'd2);
	endfunction

	// INCR realigns to the size and steps, FIXED holds
	function automatic axi_addr_u next_beat_addr(input axi_addr_u cur,
		input logic [2:0] size, input burst_e burst);
		logic [MEM_ADDR_W-1:0] step;
		axi_addr_u nxt;
		step = MEM_ADDR_W'(1) << size;
		nxt  = cur;
		// carry out of the top bit is the 4 KiB wrap
		if (burst == BURST_INCR) begin
			nxt.byte_addr = (cur.byte_addr & ~(step - MEM_ADDR_W'(1))) + step;
		end
		return nxt;
	endfunction

endpackage

`default_nettype wire

// File: source/axi_sram_slave.sv
`timescale 1ns/100ps
`default_nettype none

module axi_sram_slave
	import axi_sram_pkg::*;
(
	input  wire logic     ACLK,
	input  wire logic     ARESETn,
	// write address
	input  wire logic     aw_valid,
	input  wire axi_req_t aw,
	output logic          aw_ready,
	// write data
	input  wire logic     w_valid,
	input  wire w_beat_t  w,
	output logic          w_ready,
	// write response
	input  wire logic     b_ready,
	output logic          b_valid,
	output resp_e         b_resp,
	// read address
	input  wire logic     ar_valid,
	input  wire axi_req_t ar,
	output logic          ar_ready,
	// read data
	input  wire logic     r_ready,
	output logic          r_valid,
	output logic [DATA_W-1:0] r_data,
	output resp_e         r_resp,
	output logic          r_last
);

	// --------------------
	// engine to sram
	sram_wr_t          sram_wr;
	logic              rd_en;
	logic [IDX_W-1:0]  rd_index;
	logic [DATA_W-1:0] rd_data;

	// write path owns the sram write port
	axi_w_channel u_w_channel (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.aw_valid (aw_valid),
		.aw       (aw),
		.aw_ready (aw_ready),
		.w_valid  (w_valid),
		.w        (w),
		.w_ready  (w_ready),
		.b_ready  (b_ready),
		.b_valid  (b_valid),
		.b_resp   (b_resp),
		.sram_wr  (sram_wr)
	);

	// read path owns the read port, no arbiter needed
	axi_r_channel u_r_channel (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.ar_valid (ar_valid),
		.ar       (ar),
		.ar_ready (ar_ready),
		.r_ready  (r_ready),
		.r_valid  (r_valid),
		.r_data   (r_data),
		.r_resp   (r_resp),
		.r_last   (r_last),
		.rd_en    (rd_en),
		.rd_index (rd_index),
		.rd_data  (rd_data)
	);

	sram_dp u_sram (
		.ACLK     (ACLK),
		.wr       (sram_wr),
		.rd_en    (rd_en),
		.rd_index (rd_index),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

// File: source/axi_w_channel.sv
`timescale 1ns/100ps
`default_nettype none

module axi_w_channel
	import axi_sram_pkg::*;
(
	input  wire logic     ACLK,
	input  wire logic     ARESETn,
	// write address
	input  wire logic     aw_valid,
	input  wire axi_req_t aw,
	output logic          aw_ready,
	// write data
	input  wire logic     w_valid,
	input  wire w_beat_t  w,
	output logic          w_ready,
	// write response
	input  wire logic     b_ready,
	output logic          b_valid,
	output resp_e         b_resp,
	// to the sram write port
	output sram_wr_t      sram_wr
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_DATA,
		W_RESP
	} w_state_e;

	w_state_e          state;
	logic              aw_hs;
	logic              w_hs;
	// latched burst
	logic              err_q;
	logic [2:0]        size_q;
	burst_e            burst_q;
	axi_addr_u         addr_q;
	// sram write register
	logic              wr_en_q;
	logic [IDX_W-1:0]  wr_index_q;
	logic [DATA_W-1:0] wr_data_q;
	logic [STRB_W-1:0] wr_mask_q;
	logic [STRB_W-1:0] beat_mask;

	// lanes from the beat offset up to the end of its size-aligned window
	function automatic logic [STRB_W-1:0] lane_mask(input axi_addr_u a, input logic [2:0] size);
		logic [STRB_W-1:0] window;
		logic [OFFS_W-1:0] base;
		case (size)
			3'd0: begin
				window = 4'b0001;
				base   = a.word.offset;
			end
			3'd1: begin
				window = 4'b0011;
				base   = {a.word.offset[1], 1'b0};
			end
			default: begin
				window = 4'b1111;
				base   = '0;
			end
		endcase
		// Clip the lanes below the start byte for an unaligned first beat.
		return (window << base) & ({STRB_W{1'b1}} << a.word.offset);
	endfunction

	// --------------------
	// handshakes, all decoded from the state
	assign aw_ready = (state == W_ADDR);
	assign w_ready  = (state == W_DATA);
	assign b_valid  = (state == W_RESP);

	assign aw_hs = aw_valid && aw_ready;
	assign w_hs  = w_valid && w_ready;

	assign beat_mask = lane_mask(addr_q, size_q) & w.strb;

	// idle -> accept -> data beats -> response
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state   <= W_IDLE;
			err_q   <= 1'b0;
			wr_en_q <= 1'b0;
		end else begin
			case (state)
				W_IDLE: begin
					// one accept cycle before aw_ready
					if (aw_valid) begin
						state <= W_ADDR;
					end
				end
				W_ADDR: begin
					if (aw_valid) begin
						state <= W_DATA;
						err_q <= req_error(aw);
					end
				end
				W_DATA: begin
					// beats drain to last even on error
					if (w_valid && w.last) begin
						state <= W_RESP;
					end
				end
				default: begin
					if (b_ready) begin
						state <= W_IDLE;
					end
				end
			endcase
			// error bursts never touch the sram
			wr_en_q <= w_hs && !err_q;
		end
	end

	// --------------------
	// burst parameters and beat address
	always_ff @(posedge ACLK) begin
		if (aw_hs) begin
			size_q           <= aw.size;
			burst_q          <= aw.burst;
			addr_q.byte_addr <= aw.addr[MEM_ADDR_W-1:0];
		end else if (w_hs) begin
			addr_q <= next_beat_addr(addr_q, size_q, burst_q);
		end
	end

	// write beat and response payload
	always_ff @(posedge ACLK) begin
		if (w_hs) begin
			wr_index_q <= addr_q.word.index;
			// data already sits on its own byte lanes
			wr_data_q  <= w.data;
			wr_mask_q  <= beat_mask;
		end
		if (w_hs && w.last) begin
			b_resp <= err_q ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign sram_wr = '{en: wr_en_q, index: wr_index_q, data: wr_data_q, mask: wr_mask_q};

endmodule

`default_nettype wire

// File: source/sram_dp.sv
`timescale 1ns/100ps
`default_nettype none

module sram_dp
	import axi_sram_pkg::*;
(
	input  wire logic             ACLK,
	// byte-masked write port
	input  wire sram_wr_t         wr,
	// registered read port
	input  wire logic             rd_en,
	input  wire logic [IDX_W-1:0] rd_index,
	output logic [DATA_W-1:0]     rd_data
);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	// --------------------
	// write side
	// one lane per mask bit, untouched lanes keep their bytes
	always_ff @(posedge ACLK) begin
		if (wr.en) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (wr.mask[i]) begin
					mem[wr.index][i*LANE_W +: LANE_W] <= wr.data[i*LANE_W +: LANE_W];
				end
			end
		end
	end

	// --------------------
	// read side
	// rd_data holds between reads, the read engine relies on it
	// same word written and read in one cycle returns the old value
	always_ff @(posedge ACLK) begin
		if (rd_en) begin
			rd_data <= mem[rd_index];
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
source/axi_sram_pkg.sv
source/sram_dp.sv
source/axi_w_channel.sv
source/axi_r_channel.sv
source/axi_sram_slave.sv
tests/tb_axi_sram.sv

// File: include/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// --------------------
// reference model
// lanes one beat may touch, own byte up to the end of its size-aligned block
function automatic logic [3:0] beat_lanes(input logic [11:0] a, input logic [2:0] size);
	logic [11:0] lo;
	logic [11:0] b;
	logic [3:0]  lanes;
	int          k;
	lo    = a & ~((12'd1 << size) - 12'd1);
	lanes = 4'b0000;
	for (k = 0; k < 4; k++) begin
		b = lo + 12'(k);
		if ((k < (1 << size)) && (b >= a)) begin
			lanes[b[1:0]] = 1'b1;
		end
	end
	return lanes;
endfunction

// INCR moves to the next size-aligned block, FIXED stays, 12 bits wrap at 4 KiB
function automatic logic [11:0] next_addr(input logic [11:0] a, input logic [2:0] size,
	input burst_e burst);
	int n;
	n = 1 << size;
	if (burst == BURST_INCR) begin
		// one block past the block that holds a, counted in n-byte blocks
		return 12'((int'(a) / n + 1) * n);
	end
	return a;
endfunction

// only FIXED and INCR with at most four bytes per beat are served
function automatic logic burst_error(input burst_e burst, input logic [2:0] size);
	return !(burst inside {BURST_FIXED, BURST_INCR}) || (size > 3'd2);
endfunction

task automatic model_write_beat(input logic [11:0] a, input logic [2:0] size,
	input logic [31:0] data, input logic [3:0] strb);
	logic [3:0]  lanes;
	logic [31:0] sh;
	int          k;
	lanes = beat_lanes(a, size) & strb;
	for (k = 0; k < 4; k++) begin
		sh = data >> (8 * k);
		if (lanes[k]) begin
			model_mem[{a[11:2], 2'(k)}] = sh[7:0];
		end
	end
endtask

function automatic logic [31:0] model_word(input logic [11:0] a);
	return {model_mem[{a[11:2], 2'd3}], model_mem[{a[11:2], 2'd2}],
		model_mem[{a[11:2], 2'd1}], model_mem[{a[11:2], 2'd0}]};
endfunction

// --------------------
// stimulus helpers
function automatic logic [31:0] rand_word();
	return $random(seed);
endfunction

task automatic fill_beats(input int len, input logic full);
	logic [31:0] r;
	int          i;
	for (i = 0; i <= len; i++) begin
		wdata[8'(i)] = rand_word();
		r = rand_word();
		wstrb[8'(i)] = full ? 4'hF : r[3:0];
	end
endtask

function automatic axi_req_t make_req(input int addr, input int len, input int size,
	input burst_e burst);
	axi_req_t req;
	req.addr  = addr;
	req.len   = 8'(len);
	req.size  = 3'(size);
	req.burst = burst;
	return req;
endfunction

// ready seen at a falling edge means the transfer lands on the next rising edge
task automatic send_request(input logic is_write, input axi_req_t req);
	int n;
	n = 0;
	req_seen = 1'b1;
	if (is_write) begin
		aw       = req;
		aw_valid = 1'b1;
	end else begin
		ar       = req;
		ar_valid = 1'b1;
	end
	while (!(is_write ? aw_ready : ar_ready)) begin
		@(negedge ACLK);
		n++;
		if (n > max_wait) begin
			abort_run("timeout waiting for aw_ready or ar_ready");
		end
	end
	@(negedge ACLK);
	aw_valid = 1'b0;
	ar_valid = 1'b0;
endtask

// --------------------
// write burst from wdata and wstrb, model follows only for served bursts
task automatic write_burst(input int addr, input int len, input int size, input burst_e burst);
	logic [11:0] a;
	logic [2:0]  sz;
	logic [31:0] r;
	logic        err;
	logic        done;
	int          i;
	int          n;
	sz         = 3'(size);
	a          = 12'(addr);
	err        = burst_error(burst, sz);
	exp_b_resp = err ? RESP_SLVERR : RESP_OKAY;
	send_request(1'b1, make_req(addr, len, size, burst));
	for (i = 0; i <= len; i++) begin
		// random gap before the beat
		if (stall_en) begin
			w_valid = 1'b0;
			repeat (rand_word() % 3) @(negedge ACLK);
		end
		w.data  = wdata[8'(i)];
		w.strb  = wstrb[8'(i)];
		w.last  = (i == len);
		w_valid = 1'b1;
		n = 0;
		while (!w_ready) begin
			@(negedge ACLK);
			n++;
			if (n > max_wait) begin
				abort_run("timeout waiting for w_ready");
			end
		end
		@(negedge ACLK);
		if (!err) begin
			model_write_beat(a, sz, wdata[8'(i)], wstrb[8'(i)]);
		end
		a = next_addr(a, sz, burst);
	end
	w_valid = 1'b0;
	// response, b_ready dropped at random while stalling
	n    = 0;
	done = 1'b0;
	while (!done) begin
		r       = rand_word();
		b_ready = stall_en ? r[0] : 1'b1;
		done    = b_valid && b_ready;
		@(negedge ACLK);
		n++;
		if (n > max_wait) begin
			abort_run("timeout waiting for b_valid");
		end
	end
	b_ready = 1'b0;
endtask

// read burst, expected beats loaded for the R checks before AR goes out
task automatic read_burst(input int addr, input int len, input int size, input burst_e burst);
	logic [11:0] a;
	logic [2:0]  sz;
	logic [31:0] r;
	logic        err;
	int          i;
	int          n;
	int          got;
	sz  = 3'(size);
	a   = 12'(addr);
	err = burst_error(burst, sz);
	for (i = 0; i <= len; i++) begin
		exp_data[8'(i)] = err ? 32'd0 : model_word(a);
		exp_resp[8'(i)] = err ? RESP_SLVERR : RESP_OKAY;
		a = next_addr(a, sz, burst);
	end
	exp_rlen = 8'(len);
	send_request(1'b0, make_req(addr, len, size, burst));
	n   = 0;
	got = 0;
	while (got <= len) begin
		r       = rand_word();
		r_ready = stall_en ? r[0] : 1'b1;
		if (r_valid && r_ready) begin
			got++;
		end
		@(negedge ACLK);
		n++;
		if (n > max_wait) begin
			abort_run("timeout waiting for the R beats of a read burst");
		end
	end
	r_ready = 1'b0;
endtask

`endif

// File: tests/tb_axi_sram.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_sram
	import axi_sram_pkg::*;
();

	logic              ACLK;
	logic              ARESETn;
	logic              aw_valid;
	axi_req_t          aw;
	logic              aw_ready;
	logic              w_valid;
	w_beat_t           w;
	logic              w_ready;
	logic              b_ready;
	logic              b_valid;
	resp_e             b_resp;
	logic              ar_valid;
	axi_req_t          ar;
	logic              ar_ready;
	logic              r_ready;
	logic              r_valid;
	logic [DATA_W-1:0] r_data;
	resp_e             r_resp;
	logic              r_last;

	// --------------------
	// stimulus and model state
	integer      seed;
	int          max_wait = 4000;
	logic        stall_en;
	logic        req_seen;
	logic [7:0]  model_mem [4096];
	logic [31:0] wdata [256];
	logic [3:0]  wstrb [256];
	// expected responses
	resp_e       exp_b_resp;
	logic [7:0]  exp_rlen;
	logic [31:0] exp_data [256];
	resp_e       exp_resp [256];
	// beat number of the next R transfer
	logic [7:0]  r_beat = 8'd0;
	logic [31:0] exp_cur_data;
	resp_e       exp_cur_resp;
	logic        exp_cur_last;

	axi_sram_slave dut (.*);

	initial begin
		ACLK = 1'b0;
		forever #50 ACLK = ~ACLK;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	`include "tb_axi_tasks.svh"

	assign exp_cur_data = exp_data[r_beat];
	assign exp_cur_resp = exp_resp[r_beat];
	assign exp_cur_last = (r_beat == exp_rlen);

	always @(posedge ACLK) begin
		if (r_valid && r_ready) begin
			r_beat <= (r_beat == exp_rlen) ? 8'd0 : r_beat + 8'd1;
		end
	end

	// --------------------
	// checks
	// quiet outputs in reset and up to the first request
	idle_quiet: assert property (@(posedge ACLK) !req_seen |->
		!aw_ready && !w_ready && !b_valid && !ar_ready && !r_valid && !dut.sram_wr.en)
		else abort_run("a ready, a valid or the sram write enable is high before any request");
	aw_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else abort_run("aw_valid or its payload changed before aw_ready");
	w_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else abort_run("w_valid or its payload changed before w_ready");
	ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else abort_run("ar_valid or its payload changed before ar_ready");
	b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		b_valid && !b_ready |=> b_valid && $stable(b_resp))
		else abort_run("b_valid or b_resp changed while b_ready was low");
	r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp) && $stable(r_last))
		else abort_run("r_valid or its payload changed while r_ready was low");
	b_resp_match: assert property (@(posedge ACLK) disable iff (!ARESETn)
		b_valid && b_ready |-> b_resp == exp_b_resp)
		else value_error("b_resp", 32'($sampled(b_resp)), 32'($sampled(exp_b_resp)));
	r_data_match: assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && r_ready |-> r_data == exp_cur_data)
		else value_error("r_data", $sampled(r_data), $sampled(exp_cur_data));
	r_resp_match: assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && r_ready |-> r_resp == exp_cur_resp)
		else value_error("r_resp", 32'($sampled(r_resp)), 32'($sampled(exp_cur_resp)));
	r_last_match: assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && r_ready |-> r_last == exp_cur_last)
		else value_error("r_last", 32'($sampled(r_last)), 32'($sampled(exp_cur_last)));

	// --------------------
	// test sequence
	initial begin
		int k;
		seed     = 43414;
		stall_en = 1'b0;
		req_seen = 1'b0;
		ARESETn  = 1'b0;
		aw_valid = 1'b0;
		aw       = '0;
		w_valid  = 1'b0;
		w        = '0;
		b_ready  = 1'b0;
		ar_valid = 1'b0;
		ar       = '0;
		r_ready  = 1'b0;
		repeat (8) @(posedge ACLK);
		@(negedge ACLK);
		ARESETn = 1'b1;
		// idle outputs stay low for a while
		repeat (4) @(negedge ACLK);
		// whole memory to known random words, model in step
		for (k = 0; k < 4; k++) begin
			fill_beats(255, 1'b1);
			write_burst(k * 'h400, 255, 2, BURST_INCR);
		end
		// full-word INCR, 16 beats
		fill_beats(15, 1'b1);
		write_burst('h100, 15, 2, BURST_INCR);
		read_burst('h100, 15, 2, BURST_INCR);
		// narrow and unaligned INCR, random strobes
		fill_beats(9, 1'b0);
		write_burst('h203, 9, 0, BURST_INCR);
		fill_beats(6, 1'b0);
		write_burst('h241, 6, 1, BURST_INCR);
		fill_beats(3, 1'b0);
		write_burst('h2A6, 3, 2, BURST_INCR);
		read_burst('h200, 47, 2, BURST_INCR);
		// FIXED merges every beat into one word
		fill_beats(7, 1'b0);
		write_burst('h305, 7, 0, BURST_FIXED);
		fill_beats(5, 1'b0);
		write_burst('h312, 5, 1, BURST_FIXED);
		fill_beats(4, 1'b0);
		write_burst('h320, 4, 2, BURST_FIXED);
		read_burst('h300, 15, 2, BURST_INCR);
		read_burst('h320, 3, 2, BURST_FIXED);
		// back-pressure everywhere, 256 beats wrapping past 4 KiB
		stall_en = 1'b1;
		fill_beats(255, 1'b0);
		write_burst('hF00, 255, 2, BURST_INCR);
		read_burst('hF00, 255, 2, BURST_INCR);
		fill_beats(12, 1'b0);
		write_burst('h5FD, 12, 1, BURST_INCR);
		read_burst('h5F0, 15, 2, BURST_INCR);
		stall_en = 1'b0;
		// unsupported bursts, SLVERR and memory untouched
		fill_beats(3, 1'b1);
		write_burst('h400, 3, 2, BURST_WRAP);
		fill_beats(3, 1'b1);
		write_burst('h440, 3, 3, BURST_INCR);
		read_burst('h400, 31, 2, BURST_INCR);
		read_burst('h400, 3, 2, BURST_WRAP);
		read_burst('h440, 1, 3, BURST_INCR);
		repeat (4) @(negedge ACLK);
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
